// File: Makefile
TOP = routing_select_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f routing_select.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

// File: logic/hop_selector.sv
`timescale 1ns/100ps
`default_nettype none

module hop_selector (
	input wire clock,
	input wire nrst,
	input wire score_valid,
	input wire routing_pkg::score_t score_data,
	input wire hit_valid,
	input wire routing_pkg::sink_hit_t hit_data,
	input wire routing_pkg::neighbor_t best_entry,
	input wire result_ready,
	output routing_pkg::idx_t best_index,
	output logic result_valid,
	output routing_pkg::route_result_t result_data,
	output logic result_taken
);

	routing_pkg::word_t best_val;
	routing_pkg::idx_t best_idx;
	routing_pkg::idx_t sink_idx;
	routing_pkg::count_t count;
	logic first;
	logic take;
	routing_pkg::word_t base_val;
	routing_pkg::idx_t base_idx;
	routing_pkg::idx_t base_sink;
	routing_pkg::count_t base_cnt;
	routing_pkg::word_t next_val;
	routing_pkg::idx_t next_idx;
	routing_pkg::idx_t next_sink;
	routing_pkg::count_t next_cnt;

	always_comb begin
		first = (score_data.index == '0); // new scan starts over
		base_val = first ? routing_pkg::WORST_VALUE : best_val;
		base_idx = first ? routing_pkg::NO_HOP : best_idx;
		base_sink = first ? routing_pkg::NO_HOP : sink_idx;
		base_cnt = first ? '0 : count;
		take = score_data.better && (score_data.weighted < base_val); // strict, lowest index wins
		next_val = take ? score_data.weighted : base_val;
		next_idx = take ? score_data.index : base_idx;
		next_cnt = base_cnt + routing_pkg::count_t'(score_data.better);
		next_sink = hit_data.hit ? hit_data.index : base_sink; // ascending scan keeps highest
	end

	assign best_index = next_idx; // table looks up the id
	assign result_taken = result_valid && result_ready;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			best_val <= routing_pkg::WORST_VALUE;
			best_idx <= routing_pkg::NO_HOP;
			sink_idx <= routing_pkg::NO_HOP;
			count <= '0;
			result_valid <= 1'b0;
		end else begin
			if (score_valid) begin
				best_val <= next_val;
				best_idx <= next_idx;
				sink_idx <= next_sink;
				count <= next_cnt;
			end
			if (score_valid && score_data.last)
				result_valid <= 1'b1;
			else if (result_taken)
				result_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (score_valid && score_data.last) begin
			result_data.best_hop <= next_idx;
			result_data.best_value <= next_val;
			result_data.best_neighbor_id <= (next_idx == routing_pkg::NO_HOP) ?
				'0 : best_entry.neighbor_id;
			result_data.next_sink <= next_sink;
			result_data.better_count <= next_cnt;
		end
	end

	a_judges_aligned: assert property (@(posedge clock) disable iff (!nrst)
		(score_valid == hit_valid) && (!score_valid ||
		(hit_data.index == score_data.index && hit_data.last == score_data.last)));

	a_result_held: assert property (@(posedge clock) disable iff (!nrst)
		result_valid && !result_ready |=> result_valid && $stable(result_data));

endmodule

`default_nettype wire

// File: logic/neighbor_table.sv
`timescale 1ns/100ps
`default_nettype none

module neighbor_table #(
	parameter int NUM_NEIGHBORS = 64,
	parameter int NUM_SINKS = 16
) (
	input wire clock,
	input wire nrst,
	input wire nb_valid,
	output logic nb_ready,
	input wire routing_pkg::idx_t nb_index,
	input wire routing_pkg::neighbor_t nb_data,
	input wire sink_valid,
	output logic sink_ready,
	input wire routing_pkg::idx_t sink_index,
	input wire routing_pkg::word_t sink_data,
	input wire query_valid,
	output logic query_ready,
	input wire routing_pkg::query_t query_data,
	output logic scan_valid,
	output routing_pkg::scan_t scan_data,
	output routing_pkg::word_t [NUM_SINKS-1:0] sink_list,
	input wire result_taken,
	input wire routing_pkg::idx_t best_index,
	output routing_pkg::neighbor_t best_entry
);

	localparam int IW = $clog2(NUM_NEIGHBORS);
	localparam int SW = $clog2(NUM_SINKS);
	localparam routing_pkg::idx_t LAST_IDX = routing_pkg::idx_t'(NUM_NEIGHBORS - 1);

	routing_pkg::scan_state_t state;
	routing_pkg::neighbor_t nb_mem [NUM_NEIGHBORS];
	routing_pkg::query_t query_reg;
	routing_pkg::idx_t scan_idx;
	logic query_fire;
	logic nb_take;
	logic sink_take;
	logic nb_pend;
	logic sink_pend;
	routing_pkg::idx_t nb_pend_index;
	routing_pkg::idx_t sink_pend_index;
	routing_pkg::neighbor_t nb_pend_data;
	routing_pkg::word_t sink_pend_data;

	assign nb_ready = (state == routing_pkg::st_idle);
	assign sink_ready = (state == routing_pkg::st_idle);
	assign query_ready = (state == routing_pkg::st_idle);
	assign query_fire = query_valid && query_ready;
	assign nb_take = nb_valid && nb_ready && (int'(nb_index) < NUM_NEIGHBORS);
	assign sink_take = sink_valid && sink_ready && (int'(sink_index) < NUM_SINKS);

	assign best_entry = (int'(best_index) < NUM_NEIGHBORS) ? nb_mem[best_index[IW-1:0]] : '0;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= routing_pkg::st_idle;
			scan_idx <= '0;
			scan_valid <= 1'b0;
		end else begin
			scan_valid <= (state == routing_pkg::st_scan);
			case (state)
				routing_pkg::st_idle: begin
					if (query_fire) begin
						state <= routing_pkg::st_scan;
						scan_idx <= '0;
					end
				end
				routing_pkg::st_scan: begin
					scan_idx <= scan_idx + 1'b1; // one neighbor per cycle
					if (scan_idx == LAST_IDX)
						state <= routing_pkg::st_hold;
				end
				routing_pkg::st_hold: begin
					if (result_taken)
						state <= routing_pkg::st_idle;
				end
				default: state <= routing_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (query_fire)
			query_reg <= query_data;
		if (state == routing_pkg::st_scan) begin
			scan_data.index <= scan_idx;
			scan_data.entry <= nb_mem[scan_idx[IW-1:0]];
			scan_data.query <= query_reg; // same query on every item
			scan_data.last <= (scan_idx == LAST_IDX);
		end
	end

	// a load that arrives with the query waits until the scan is done
	always_ff @(posedge clock) begin
		if (!nrst) begin
			nb_pend <= 1'b0;
			sink_pend <= 1'b0;
		end else begin
			if (nb_take && query_fire)
				nb_pend <= 1'b1;
			else if (result_taken)
				nb_pend <= 1'b0;
			if (sink_take && query_fire)
				sink_pend <= 1'b1;
			else if (result_taken)
				sink_pend <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (nb_take && query_fire) begin
			nb_pend_index <= nb_index;
			nb_pend_data <= nb_data;
		end
		if (sink_take && query_fire) begin
			sink_pend_index <= sink_index;
			sink_pend_data <= sink_data;
		end
	end

	always_ff @(posedge clock) begin
		if (nb_take && !query_fire)
			nb_mem[nb_index[IW-1:0]] <= nb_data;
		else if (result_taken && nb_pend)
			nb_mem[nb_pend_index[IW-1:0]] <= nb_pend_data; // deferred write
	end

	always_ff @(posedge clock) begin
		if (!nrst)
			sink_list <= '1; // ffff until loaded
		else if (sink_take && !query_fire)
			sink_list[sink_index[SW-1:0]] <= sink_data;
		else if (result_taken && sink_pend)
			sink_list[sink_pend_index[SW-1:0]] <= sink_pend_data;
	end

	a_load_only_idle: assert property (@(posedge clock) disable iff (!nrst)
		(nb_valid && nb_ready) || (sink_valid && sink_ready) |->
		state == routing_pkg::st_idle && !scan_valid && !nb_pend && !sink_pend);

endmodule

`default_nettype wire

// File: logic/qvalue_scorer.sv
`timescale 1ns/100ps
`default_nettype none

module qvalue_scorer #(
	parameter routing_pkg::word_t BATTERY_THRESHOLD = 16'd655
) (
	input wire clock,
	input wire nrst,
	input wire scan_valid,
	input wire routing_pkg::scan_t scan_data,
	output logic score_valid,
	output routing_pkg::score_t score_data
);

	logic live;
	logic better;
	logic [19:0] battery_x10;
	logic [3:0] level;
	logic s1_valid;
	logic s1_better;
	logic s1_last;
	routing_pkg::idx_t s1_index;
	routing_pkg::word_t s1_qvalue;
	logic [3:0] s1_level;
	logic [31:0] product;
	routing_pkg::word_t weighted;

	always_comb begin
		live = (scan_data.entry.cluster_id == scan_data.query.my_cluster) &&
			(scan_data.entry.battery >= BATTERY_THRESHOLD);
		better = live && (scan_data.entry.qvalue <= scan_data.query.my_best);
		battery_x10 = 20'(scan_data.entry.battery) * 20'd10;
		// ceiling of 10 * battery, reaches 10 at battery ffff
		level = battery_x10[19:16] + 4'(|battery_x10[15:0]);
	end

	always_ff @(posedge clock) begin
		if (!nrst)
			s1_valid <= 1'b0;
		else
			s1_valid <= scan_valid;
	end

	always_ff @(posedge clock) begin
		if (scan_valid) begin
			s1_index <= scan_data.index;
			s1_better <= better;
			s1_last <= scan_data.last;
			s1_qvalue <= scan_data.entry.qvalue;
			s1_level <= level;
		end
	end

	always_comb begin
		product = 32'(s1_qvalue) * 32'(routing_pkg::HCM_WEIGHT[s1_level]); // Q16.16
		weighted = (|product[31:24]) ? 16'hFFFF : product[23:8]; // back to Q8.8
	end

	always_ff @(posedge clock) begin
		if (!nrst)
			score_valid <= 1'b0;
		else
			score_valid <= s1_valid;
	end

	always_ff @(posedge clock) begin
		if (s1_valid) begin
			score_data.index <= s1_index;
			score_data.better <= s1_better;
			score_data.weighted <= weighted;
			score_data.last <= s1_last;
		end
	end

	a_level_in_table: assert property (@(posedge clock) disable iff (!nrst)
		s1_valid |-> int'(s1_level) < routing_pkg::HCM_LENGTH);

endmodule

`default_nettype wire

// File: logic/routing_pkg.sv
`default_nettype none

package routing_pkg;

	typedef logic [15:0] word_t; // ids, Q8.8 values, Q0.16 battery
	typedef logic [7:0] idx_t;
	typedef logic [23:0] count_t; // better neighbor count

	localparam idx_t NO_HOP = 8'd255; // nothing found
	localparam word_t WORST_VALUE = 16'hFFFE; // start of running minimum
	localparam int HCM_LENGTH = 11;

	// hop-cost weights in Q8.8, low battery costs more
	localparam word_t HCM_WEIGHT [0:HCM_LENGTH-1] = '{
		16'h0A00, 16'h0900, 16'h0800, 16'h0700, 16'h0600, 16'h0500,
		16'h0400, 16'h0300, 16'h0200, 16'h0180, 16'h0100
	};

	typedef struct packed {
		word_t neighbor_id;
		word_t cluster_id;
		word_t battery; // Q0.16
		word_t qvalue; // Q8.8
	} neighbor_t;

	typedef struct packed {
		word_t my_cluster;
		word_t my_best; // Q8.8
	} query_t;

	typedef struct packed {
		idx_t index;
		neighbor_t entry;
		query_t query;
		logic last; // final index of the scan
	} scan_t;

	typedef struct packed {
		idx_t index;
		logic better;
		word_t weighted; // Q8.8, saturated
		logic last;
	} score_t;

	typedef struct packed {
		idx_t index;
		logic hit;
		logic last;
	} sink_hit_t;

	typedef struct packed {
		idx_t best_hop;
		word_t best_value;
		word_t best_neighbor_id;
		idx_t next_sink;
		count_t better_count;
	} route_result_t;

	typedef enum logic [1:0] {
		st_idle,
		st_scan,
		st_hold
	} scan_state_t;

endpackage

`default_nettype wire

// File: logic/routing_select.sv
`timescale 1ns/100ps
`default_nettype none

module routing_select #(
	parameter int NUM_NEIGHBORS = 64,
	parameter int NUM_SINKS = 16,
	parameter routing_pkg::word_t BATTERY_THRESHOLD = 16'd655 // about 0.01 in Q0.16
) (
	input wire clock,
	input wire nrst,
	input wire nb_valid,
	output logic nb_ready,
	input wire routing_pkg::idx_t nb_index,
	input wire routing_pkg::neighbor_t nb_data,
	input wire sink_valid,
	output logic sink_ready,
	input wire routing_pkg::idx_t sink_index,
	input wire routing_pkg::word_t sink_data,
	input wire query_valid,
	output logic query_ready,
	input wire routing_pkg::query_t query_data,
	output logic result_valid,
	input wire result_ready,
	output routing_pkg::route_result_t result_data
);

	logic scan_valid;
	routing_pkg::scan_t scan_data;
	routing_pkg::word_t [NUM_SINKS-1:0] sink_list;
	logic score_valid;
	routing_pkg::score_t score_data;
	logic hit_valid;
	routing_pkg::sink_hit_t hit_data;
	routing_pkg::idx_t best_index;
	routing_pkg::neighbor_t best_entry;
	logic result_taken;

	neighbor_table #(
		.NUM_NEIGHBORS(NUM_NEIGHBORS),
		.NUM_SINKS(NUM_SINKS)
	) neighbor_table_i (
		.clock(clock),
		.nrst(nrst),
		.nb_valid(nb_valid),
		.nb_ready(nb_ready),
		.nb_index(nb_index),
		.nb_data(nb_data),
		.sink_valid(sink_valid),
		.sink_ready(sink_ready),
		.sink_index(sink_index),
		.sink_data(sink_data),
		.query_valid(query_valid),
		.query_ready(query_ready),
		.query_data(query_data),
		.scan_valid(scan_valid),
		.scan_data(scan_data),
		.sink_list(sink_list),
		.result_taken(result_taken),
		.best_index(best_index),
		.best_entry(best_entry)
	);

	qvalue_scorer #(
		.BATTERY_THRESHOLD(BATTERY_THRESHOLD)
	) qvalue_scorer_i (
		.clock(clock),
		.nrst(nrst),
		.scan_valid(scan_valid),
		.scan_data(scan_data),
		.score_valid(score_valid),
		.score_data(score_data)
	);

	sink_matcher #(
		.NUM_SINKS(NUM_SINKS),
		.BATTERY_THRESHOLD(BATTERY_THRESHOLD)
	) sink_matcher_i (
		.clock(clock),
		.nrst(nrst),
		.scan_valid(scan_valid),
		.scan_data(scan_data),
		.sink_list(sink_list),
		.hit_valid(hit_valid),
		.hit_data(hit_data)
	);

	hop_selector hop_selector_i (
		.clock(clock),
		.nrst(nrst),
		.score_valid(score_valid),
		.score_data(score_data),
		.hit_valid(hit_valid),
		.hit_data(hit_data),
		.best_entry(best_entry),
		.result_ready(result_ready),
		.best_index(best_index),
		.result_valid(result_valid),
		.result_data(result_data),
		.result_taken(result_taken)
	);

endmodule

`default_nettype wire

// File: logic/sink_matcher.sv
`timescale 1ns/100ps
`default_nettype none

module sink_matcher #(
	parameter int NUM_SINKS = 16,
	parameter routing_pkg::word_t BATTERY_THRESHOLD = 16'd655
) (
	input wire clock,
	input wire nrst,
	input wire scan_valid,
	input wire routing_pkg::scan_t scan_data,
	input wire routing_pkg::word_t [NUM_SINKS-1:0] sink_list,
	output logic hit_valid,
	output routing_pkg::sink_hit_t hit_data
);

	logic live;
	logic match;
	logic h1_valid;
	routing_pkg::sink_hit_t h1_data;

	always_comb begin
		live = (scan_data.entry.cluster_id == scan_data.query.my_cluster) &&
			(scan_data.entry.battery >= BATTERY_THRESHOLD);
		match = 1'b0;
		for (int s = 0; s < NUM_SINKS; s++) begin
			if (scan_data.entry.neighbor_id == sink_list[s])
				match = 1'b1; // any sink will do
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			h1_valid <= 1'b0;
			hit_valid <= 1'b0;
		end else begin
			h1_valid <= scan_valid;
			hit_valid <= h1_valid; // extra stage to line up with scorer
		end
	end

	always_ff @(posedge clock) begin
		if (scan_valid) begin
			h1_data.index <= scan_data.index;
			h1_data.hit <= live && match;
			h1_data.last <= scan_data.last;
		end
		if (h1_valid)
			hit_data <= h1_data;
	end

endmodule

`default_nettype wire

// File: routing_select.f
+incdir+verif
logic/routing_pkg.sv
logic/neighbor_table.sv
logic/qvalue_scorer.sv
logic/sink_matcher.sv
logic/hop_selector.sv
logic/routing_select.sv
verif/routing_select_tb.sv

// File: verif/routing_model.svh
`ifndef ROUTING_MODEL_SVH
`define ROUTING_MODEL_SVH

// Q8.8 hop-cost weights, 10.0 for an empty battery down to 1.0 for a full one
localparam logic [15:0] MODEL_WEIGHT [0:10] = '{
	16'h0A00, 16'h0900, 16'h0800, 16'h0700, 16'h0600, 16'h0500,
	16'h0400, 16'h0300, 16'h0200, 16'h0180, 16'h0100
};

// fibonacci form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

function automatic logic [15:0] weigh(input logic [15:0] battery, input logic [15:0] qvalue);
	int k;
	longint prod;
	k = (int'(battery) * 10 + 65535) / 65536; // ceiling of 10 * battery
	if (k > 10)
		k = 10;
	prod = longint'(qvalue) * longint'(MODEL_WEIGHT[k]);
	prod = prod / 256; // Q16.16 down to Q8.8
	if (prod > 65535)
		return 16'hFFFF;
	return 16'(prod);
endfunction

function automatic routing_pkg::route_result_t model_route(
	input routing_pkg::neighbor_t tbl [NN],
	input routing_pkg::word_t snk [NS],
	input routing_pkg::query_t q
);
	routing_pkg::route_result_t r;
	logic live;
	logic sink_hit;
	logic [15:0] w;
	r.best_hop = 8'd255; // none found
	r.best_value = 16'hFFFE;
	r.best_neighbor_id = 16'h0000;
	r.next_sink = 8'd255;
	r.better_count = 24'd0;
	for (int i = 0; i < NN; i++) begin
		live = (tbl[i].cluster_id == q.my_cluster) && (tbl[i].battery >= THRESHOLD);
		sink_hit = 1'b0;
		for (int s = 0; s < NS; s++) begin
			if (tbl[i].neighbor_id == snk[s])
				sink_hit = 1'b1;
		end
		if (live && sink_hit)
			r.next_sink = 8'(i); // later index overrides
		if (live && (tbl[i].qvalue <= q.my_best)) begin
			r.better_count = r.better_count + 24'd1;
			w = weigh(tbl[i].battery, tbl[i].qvalue);
			if (w < r.best_value) begin
				r.best_hop = 8'(i);
				r.best_value = w;
				r.best_neighbor_id = tbl[i].neighbor_id;
			end
		end
	end
	return r;
endfunction

`endif

// File: verif/routing_select_tb.sv
`timescale 1ns/100ps
`default_nettype none

module routing_select_tb;

	localparam int NN = 16;
	localparam int NS = 16;
	localparam logic [15:0] THRESHOLD = 16'd655;
	localparam int LIMIT = 200; // cycles before a wait gives up

	logic clock;
	logic nrst;
	logic nb_valid;
	logic nb_ready;
	routing_pkg::idx_t nb_index;
	routing_pkg::neighbor_t nb_data;
	logic sink_valid;
	logic sink_ready;
	routing_pkg::idx_t sink_index;
	routing_pkg::word_t sink_data;
	logic query_valid;
	logic query_ready;
	routing_pkg::query_t query_data;
	logic result_valid;
	logic result_ready;
	routing_pkg::route_result_t result_data;

	routing_pkg::neighbor_t table_copy [NN]; // what the DUT should hold
	routing_pkg::word_t sink_copy [NS];
	routing_pkg::route_result_t expect_q [$];
	string name_q [$];
	int accept_q [$]; // cycle of the query accept edge
	string test_name;
	int cycle;
	int errors;
	logic [31:0] lfsr_state;

	`include "routing_model.svh"

	routing_select #(
		.NUM_NEIGHBORS(NN),
		.NUM_SINKS(NS),
		.BATTERY_THRESHOLD(THRESHOLD)
	) routing_select_i (
		.clock(clock),
		.nrst(nrst),
		.nb_valid(nb_valid),
		.nb_ready(nb_ready),
		.nb_index(nb_index),
		.nb_data(nb_data),
		.sink_valid(sink_valid),
		.sink_ready(sink_ready),
		.sink_index(sink_index),
		.sink_data(sink_data),
		.query_valid(query_valid),
		.query_ready(query_ready),
		.query_data(query_data),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.result_data(result_data)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	always @(posedge clock)
		cycle = cycle + 1; // only read at negedge

	task automatic stop_with_error(input string msg);
		errors++;
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	function automatic string fmt_result(input routing_pkg::route_result_t r);
		return $sformatf("hop %0d value %h id %h sink %0d count %0d", r.best_hop,
			r.best_value, r.best_neighbor_id, r.next_sink, r.better_count);
	endfunction

	task automatic check_result(input string name, input routing_pkg::route_result_t exp,
		input routing_pkg::route_result_t act);
		if (act !== exp)
			stop_with_error($sformatf("MISMATCH %s expected (%s) actual (%s)", name,
				fmt_result(exp), fmt_result(act)));
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp)
			stop_with_error($sformatf("MISMATCH %s latency expected %0d actual %0d",
				name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_with_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic load_neighbor(input int i, input routing_pkg::neighbor_t d);
		int t;
		nb_valid = 1'b1;
		nb_index = 8'(i);
		nb_data = d;
		t = 0;
		@(negedge clock);
		while (nb_ready !== 1'b1) begin
			t++;
			if (t > LIMIT)
				stop_with_error("neighbor load was never accepted");
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		nb_valid = 1'b0;
		table_copy[i] = d;
	endtask

	task automatic load_sink(input int s, input routing_pkg::word_t id);
		int t;
		sink_valid = 1'b1;
		sink_index = 8'(s);
		sink_data = id;
		t = 0;
		@(negedge clock);
		while (sink_ready !== 1'b1) begin
			t++;
			if (t > LIMIT)
				stop_with_error("sink load was never accepted");
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		sink_valid = 1'b0;
		sink_copy[s] = id;
	endtask

	task automatic put_entry(input int i, input routing_pkg::word_t id, cl, bat, q);
		load_neighbor(i, {id, cl, bat, q});
	endtask

	task automatic fill_table(input routing_pkg::word_t id_base, cl, bat, q);
		for (int i = 0; i < NN; i++)
			put_entry(i, id_base + 16'(i), cl, bat, q);
	endtask

	task automatic fill_sinks(input routing_pkg::word_t base);
		for (int s = 0; s < NS; s++)
			load_sink(s, base + 16'(s));
	endtask

	task automatic random_table();
		routing_pkg::word_t id;
		routing_pkg::word_t cl;
		routing_pkg::word_t bat;
		routing_pkg::word_t q;
		for (int i = 0; i < NN; i++) begin
			id = 16'h0400 + 16'(random_bits(5)); // small id space so sinks collide
			cl = 16'(random_bits(2));
			bat = random_bits(1) ? 16'(random_bits(10)) : 16'(random_bits(16));
			q = random_bits(1) ? 16'(random_bits(16)) : 16'(random_bits(12));
			put_entry(i, id, cl, bat, q);
		end
		for (int s = 0; s < NS; s++)
			load_sink(s, 16'h0400 + 16'(random_bits(5)));
	endtask

	task automatic send_query(input routing_pkg::word_t cl, input routing_pkg::word_t best);
		int t;
		query_valid = 1'b1;
		query_data = {cl, best};
		t = 0;
		@(negedge clock);
		while (query_ready !== 1'b1) begin
			t++;
			if (t > LIMIT)
				stop_with_error("query was never accepted");
			@(negedge clock);
		end
		expect_q.push_back(model_route(table_copy, sink_copy, query_data));
		name_q.push_back(test_name);
		accept_q.push_back(cycle + 1); // accepted on the coming edge
		@(posedge clock);
		#1;
		query_valid = 1'b0;
	endtask

	task automatic wait_result_valid();
		int t;
		t = 0;
		@(negedge clock);
		while (result_valid !== 1'b1) begin
			t++;
			if (t > LIMIT)
				stop_with_error("result_valid never rose under back-pressure");
			@(negedge clock);
		end
	endtask

	task automatic wait_results_done();
		int t;
		t = 0;
		while (expect_q.size() != 0) begin
			t++;
			if (t > LIMIT)
				stop_with_error("expected results were not all delivered");
			@(posedge clock);
			#1;
		end
	endtask

	// compares every result with the model, at negedge where outputs are settled
	initial begin : compare_results
		int t;
		forever begin
			t = 0;
			@(negedge clock);
			while (result_valid !== 1'b1) begin
				if (expect_q.size() > 0)
					t++;
				if (t > LIMIT)
					stop_with_error("timeout waiting for result_valid");
				@(negedge clock);
			end
			if (expect_q.size() == 0)
				stop_with_error("result_valid rose with no query pending");
			check_cycles(name_q[0], NN + 3, cycle - accept_q[0]);
			check_result(name_q[0], expect_q[0], result_data);
			t = 0;
			while (result_ready !== 1'b1) begin
				check_flag({name_q[0], " query_ready"}, 1'b0, query_ready);
				check_flag({name_q[0], " nb_ready"}, 1'b0, nb_ready);
				check_flag({name_q[0], " sink_ready"}, 1'b0, sink_ready);
				t++;
				if (t > LIMIT)
					stop_with_error("result was never taken");
				@(negedge clock);
				check_flag({name_q[0], " result_valid"}, 1'b1, result_valid);
				check_result(name_q[0], expect_q[0], result_data); // must hold
			end
			void'(expect_q.pop_front());
			void'(name_q.pop_front());
			void'(accept_q.pop_front());
			@(posedge clock); // handshake edge
		end
	end

	initial begin : stimulus
		int stall;
		cycle = 0;
		errors = 0;
		lfsr_state = 32'h5bd1_3269;
		nrst = 1'b0;
		nb_valid = 1'b0;
		nb_index = '0;
		nb_data = '0;
		sink_valid = 1'b0;
		sink_index = '0;
		sink_data = '0;
		query_valid = 1'b0;
		query_data = '0;
		result_ready = 1'b1;
		repeat (4) @(posedge clock);
		#1;
		nrst = 1'b1;

		test_name = "directed table";
		fill_table(16'h0100, 16'd5, 16'h8000, 16'h0400); // other cluster
		put_entry(1, 16'h0101, 16'd3, 16'h8000, 16'h0100);
		put_entry(2, 16'h0102, 16'd3, 16'd100, 16'h0010); // below threshold
		put_entry(4, 16'h0104, 16'd3, 16'hFFFF, 16'h0600);
		put_entry(7, 16'h0107, 16'd3, 16'h4000, 16'h0080);
		put_entry(9, 16'h0109, 16'd3, 16'hE000, 16'h0900); // above my_best
		put_entry(12, 16'h010C, 16'd3, 16'd655, 16'h0040); // exactly at threshold
		fill_sinks(16'hA000);
		send_query(16'd3, 16'h0800);
		wait_results_done();

		test_name = "sink matching";
		fill_table(16'h0200, 16'd3, 16'h8000, 16'h0A00);
		put_entry(12, 16'h020C, 16'd3, 16'd10, 16'h0A00); // dead sink
		put_entry(14, 16'h020E, 16'd9, 16'h8000, 16'h0A00); // sink in other cluster
		fill_sinks(16'hB000);
		load_sink(0, 16'h0203);
		load_sink(1, 16'h020A);
		load_sink(2, 16'h020C);
		load_sink(3, 16'h020E);
		load_sink(4, 16'h0205);
		send_query(16'd3, 16'h0800);
		wait_results_done();
		test_name = "no sink match";
		fill_sinks(16'hB000);
		send_query(16'd3, 16'h0800);
		wait_results_done();

		test_name = "no eligible neighbor";
		fill_table(16'h0300, 16'd7, 16'hFFFF, 16'h0010);
		put_entry(5, 16'h0305, 16'd3, 16'd654, 16'h0010); // just under threshold
		send_query(16'd3, 16'hFFFF);
		wait_results_done();

		test_name = "weight edges";
		fill_table(16'h0500, 16'd3, 16'h8000, 16'h1000);
		put_entry(0, 16'h0500, 16'd3, 16'h0000, 16'h0100); // empty battery
		put_entry(1, 16'h0501, 16'd3, 16'hFFFF, 16'h0100); // full battery
		put_entry(2, 16'h0502, 16'd3, 16'hFFFF, 16'h0100); // tie with 1
		put_entry(3, 16'h0503, 16'd3, 16'd655, 16'hFFFF); // saturates
		put_entry(4, 16'h0504, 16'd3, 16'h1999, 16'h0200);
		put_entry(5, 16'h0505, 16'd3, 16'h199A, 16'h0200); // just past a level step
		send_query(16'd3, 16'hFFFF);
		wait_results_done();
		test_name = "saturated only";
		fill_table(16'h0600, 16'd3, 16'd655, 16'hFFFF);
		send_query(16'd3, 16'hFFFF);
		wait_results_done();

		test_name = "random tables";
		repeat (20) begin
			random_table();
			send_query(16'(random_bits(2)), 16'(random_bits(13)));
			wait_results_done();
		end

		test_name = "back-pressure";
		repeat (4) begin
			random_table();
			result_ready = 1'b0;
			send_query(16'(random_bits(2)), 16'(random_bits(13)));
			wait_result_valid();
			stall = int'(random_bits(4)) + 1;
			repeat (stall) @(posedge clock);
			#1;
			result_ready = 1'b1;
			wait_results_done();
		end
		send_query(16'(random_bits(2)), 16'(random_bits(13))); // follow-up query
		wait_results_done();

		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
